//--- hw/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

   // instruction opcodes, first nibble of an instruction
   typedef enum logic [3:0] {
      OP_ADD  = 4'h0,
      OP_SUB  = 4'h1,
      OP_MUL  = 4'h2,
      OP_DIV  = 4'h3,
      OP_NAND = 4'h4,
      OP_NOR  = 4'h5,
      OP_XOR  = 4'h6,
      OP_MOV  = 4'h7,
      OP_LD   = 4'h8,
      OP_ST   = 4'h9,
      OP_JMP  = 4'hA,
      OP_HALT = 4'hF
   } cpu_op_e;

   // same order as the first seven opcodes
   typedef enum logic [2:0] {
      ALU_ADD  = 3'd0,
      ALU_SUB  = 3'd1,
      ALU_MUL  = 3'd2,
      ALU_DIV  = 3'd3,
      ALU_NAND = 3'd4,
      ALU_NOR  = 3'd5,
      ALU_XOR  = 3'd6,
      ALU_B    = 3'd7
   } alu_op_e;

   typedef enum logic [2:0] {
      S_FETCH_OP  = 3'd0,
      S_FETCH_ARG = 3'd1,
      S_EXEC      = 3'd2,
      S_MEM       = 3'd3,
      S_HALT      = 3'd4
   } ctrl_state_e;

   typedef struct packed {
      alu_op_e alu_op;
      logic    a_sel_reg;
      logic    b_sel_reg;
      logic    ir_we;
      logic    arg_we;
      logic    pc_we;
      logic    pc_inc;
      logic    rb_we;
      logic    rb_from_mem;
   } dp_ctrl_t;

   typedef struct packed {
      cpu_op_e    op;
      logic [7:0] addr;
      logic [7:0] store_data;
      logic [7:0] fetch_addr;
   } dp_status_t;

   typedef struct packed {
      logic [7:0] addr;
      logic [7:0] wdata;
      logic       we;
   } mem_req_t;

   // index 0 is r0
   localparam logic [3:0][7:0] REG_RESET = {8'h04, 8'h03, 8'h02, 8'h01};

   localparam logic [7:0] DIV_ZERO_RESULT = 8'hFF;

endpackage

`default_nettype wire

//--- hw/cpu_alu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_alu (
   input  wire                   [7:0] a,
   input  wire                   [7:0] b,
   input  wire   cpu_pkg::alu_op_e     op,
   output logic                  [7:0] y
);

   always_comb begin
      case (op)
         cpu_pkg::ALU_ADD:  y = a + b;
         cpu_pkg::ALU_SUB:  y = a - b;
         // low byte of the product only
         cpu_pkg::ALU_MUL:  y = a * b;
         cpu_pkg::ALU_DIV: begin
            if (b == 8'h00) begin
               y = cpu_pkg::DIV_ZERO_RESULT;
            end else begin
               y = a / b;
            end
         end
         cpu_pkg::ALU_NAND: y = ~(a & b);
         cpu_pkg::ALU_NOR:  y = ~(a | b);
         cpu_pkg::ALU_XOR:  y = a ^ b;
         cpu_pkg::ALU_B:    y = b;
         default:           y = 8'h00;
      endcase
   end

endmodule

`default_nettype wire

//--- hw/cpu_reg_block.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_reg_block (
   input  wire        clk,
   input  wire        nRst,
   input  wire  [1:0] sel_a,
   input  wire  [1:0] sel_b,
   input  wire  [1:0] sel_w,
   input  wire        we,
   input  wire  [7:0] wdata,
   output logic [7:0] rdata_a,
   output logic [7:0] rdata_b
);

   logic [3:0][7:0] regs;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         regs <= cpu_pkg::REG_RESET;
      end else if (we) begin
         regs[sel_w] <= wdata;
      end
   end

   // combinational reads see a write one cycle later
   assign rdata_a = regs[sel_a];
   assign rdata_b = regs[sel_b];

endmodule

`default_nettype wire

//--- hw/cpu_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_datapath (
   input  wire                      clk,
   input  wire                      nRst,
   input  wire   cpu_pkg::dp_ctrl_t ctrl,
   input  wire                [7:0] mem_rdata,
   output cpu_pkg::dp_status_t      status
);

   logic [7:0] pc;
   logic [3:0] ir;
   logic [3:0] arg;
   logic [3:0] nibble;

   logic [7:0] rdata_a;
   logic [7:0] rdata_b;
   logic [7:0] alu_a;
   logic [7:0] alu_b;
   logic [7:0] alu_y;
   logic [7:0] rb_wdata;

   // odd pc takes the upper half of the fetched byte
   assign nibble = pc[0] ? mem_rdata[7:4] : mem_rdata[3:0];

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         pc  <= 8'h00;
         ir  <= 4'h0;
         arg <= 4'h0;
      end else begin
         if (ctrl.ir_we) begin
            ir <= nibble;
         end
         if (ctrl.arg_we) begin
            arg <= nibble;
         end
         if (ctrl.pc_we) begin
            pc <= alu_y;
         end else if (ctrl.pc_inc) begin
            pc <= pc + 8'h01;
         end
      end
   end

   // operand holds dst in [3:2] and src in [1:0]
   cpu_reg_block u_reg_block (
      .clk     (clk),
      .nRst    (nRst),
      .sel_a   (arg[3:2]),
      .sel_b   (arg[1:0]),
      .sel_w   (arg[3:2]),
      .we      (ctrl.rb_we),
      .wdata   (rb_wdata),
      .rdata_a (rdata_a),
      .rdata_b (rdata_b)
   );

   assign alu_a = ctrl.a_sel_reg ? rdata_a : pc;
   assign alu_b = ctrl.b_sel_reg ? rdata_b : pc;

   cpu_alu u_alu (
      .a  (alu_a),
      .b  (alu_b),
      .op (ctrl.alu_op),
      .y  (alu_y)
   );

   assign rb_wdata = ctrl.rb_from_mem ? mem_rdata : alu_y;

   assign status.op         = cpu_pkg::cpu_op_e'(ir);
   assign status.addr       = rdata_b;
   assign status.store_data = rdata_a;
   // two nibbles per byte
   assign status.fetch_addr = {1'b0, pc[7:1]};

endmodule

`default_nettype wire

//--- hw/cpu_control.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_control (
   input  wire                        clk,
   input  wire                        nRst,
   input  wire   cpu_pkg::dp_status_t status,
   input  wire                        done,
   output cpu_pkg::dp_ctrl_t          ctrl,
   output logic                       start,
   output cpu_pkg::mem_req_t          cmd,
   output logic                       halted
);

   cpu_pkg::ctrl_state_e state;
   cpu_pkg::ctrl_state_e next_state;
   logic                 busy;
   logic                 busy_next;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state <= cpu_pkg::S_FETCH_OP;
         busy  <= 1'b0;
      end else begin
         state <= next_state;
         busy  <= busy_next;
      end
   end

   always_comb begin
      ctrl        = '0;
      ctrl.alu_op = cpu_pkg::ALU_B;
      start       = 1'b0;
      cmd         = '0;
      next_state  = state;
      busy_next   = busy;

      case (state)
         cpu_pkg::S_FETCH_OP, cpu_pkg::S_FETCH_ARG: begin
            cmd.addr = status.fetch_addr;
            if (!busy) begin
               start     = 1'b1;
               busy_next = 1'b1;
            end else if (done) begin
               busy_next   = 1'b0;
               ctrl.pc_inc = 1'b1;
               if (state == cpu_pkg::S_FETCH_OP) begin
                  ctrl.ir_we = 1'b1;
                  next_state = cpu_pkg::S_FETCH_ARG;
               end else begin
                  ctrl.arg_we = 1'b1;
                  next_state  = cpu_pkg::S_EXEC;
               end
            end
         end

         cpu_pkg::S_EXEC: begin
            next_state = cpu_pkg::S_FETCH_OP;
            case (status.op)
               cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_MUL, cpu_pkg::OP_DIV,
               cpu_pkg::OP_NAND, cpu_pkg::OP_NOR, cpu_pkg::OP_XOR: begin
                  // low three opcode bits pick the ALU function
                  ctrl.alu_op    = cpu_pkg::alu_op_e'(status.op[2:0]);
                  ctrl.a_sel_reg = 1'b1;
                  ctrl.b_sel_reg = 1'b1;
                  ctrl.rb_we     = 1'b1;
               end
               cpu_pkg::OP_MOV: begin
                  ctrl.b_sel_reg = 1'b1;
                  ctrl.rb_we     = 1'b1;
               end
               cpu_pkg::OP_LD: begin
                  start      = 1'b1;
                  cmd.addr   = status.addr;
                  next_state = cpu_pkg::S_MEM;
               end
               cpu_pkg::OP_ST: begin
                  start      = 1'b1;
                  cmd.addr   = status.addr;
                  cmd.wdata  = status.store_data;
                  cmd.we     = 1'b1;
                  next_state = cpu_pkg::S_MEM;
               end
               cpu_pkg::OP_JMP: begin
                  ctrl.b_sel_reg = 1'b1;
                  ctrl.pc_we     = 1'b1;
               end
               cpu_pkg::OP_HALT: begin
                  next_state = cpu_pkg::S_HALT;
               end
               default: begin
                  // unused codes fall through as nop
                  next_state = cpu_pkg::S_FETCH_OP;
               end
            endcase
         end

         cpu_pkg::S_MEM: begin
            if (done) begin
               next_state = cpu_pkg::S_FETCH_OP;
               if (status.op == cpu_pkg::OP_LD) begin
                  ctrl.rb_we       = 1'b1;
                  ctrl.rb_from_mem = 1'b1;
               end
            end
         end

         cpu_pkg::S_HALT: begin
            next_state = cpu_pkg::S_HALT;
         end

         default: begin
            next_state = cpu_pkg::S_FETCH_OP;
         end
      endcase
   end

   assign halted = (state == cpu_pkg::S_HALT);

endmodule

`default_nettype wire

//--- hw/cpu_bus_master.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_bus_master (
   input  wire                      clk,
   input  wire                      nRst,
   input  wire                      start,
   input  wire   cpu_pkg::mem_req_t cmd,
   output logic                     done,
   output logic               [7:0] rdata,
   output logic                     mem_req,
   output cpu_pkg::mem_req_t        mem_cmd,
   input  wire                      mem_ack,
   input  wire                [7:0] mem_rdata
);

   typedef enum logic [1:0] {
      BM_IDLE = 2'd0,
      BM_REQ  = 2'd1,
      BM_REL  = 2'd2
   } bm_state_e;

   bm_state_e state;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state   <= BM_IDLE;
         mem_req <= 1'b0;
         mem_cmd <= '0;
         done    <= 1'b0;
      end else begin
         done <= 1'b0;
         case (state)
            BM_IDLE: begin
               // ack is already low here, so req may rise
               if (start) begin
                  mem_cmd <= cmd;
                  mem_req <= 1'b1;
                  state   <= BM_REQ;
               end
            end
            BM_REQ: begin
               if (mem_ack) begin
                  mem_req <= 1'b0;
                  state   <= BM_REL;
               end
            end
            BM_REL: begin
               if (!mem_ack) begin
                  done  <= 1'b1;
                  state <= BM_IDLE;
               end
            end
            default: begin
               state <= BM_IDLE;
            end
         endcase
      end
   end

   // capture on the first cycle ack is seen high
   always_ff @(posedge clk) begin
      if (state == BM_REQ && mem_ack && !mem_cmd.we) begin
         rdata <= mem_rdata;
      end
   end

endmodule

`default_nettype wire

//--- hw/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
   input  wire                      clk,
   input  wire                      nRst,
   output wire                      mem_req,
   output wire   cpu_pkg::mem_req_t mem_cmd,
   input  wire                      mem_ack,
   input  wire                [7:0] mem_rdata,
   output wire                      halted
);

   wire cpu_pkg::dp_ctrl_t   ctrl;
   wire cpu_pkg::dp_status_t status;
   wire cpu_pkg::mem_req_t   cmd;
   wire                      start;
   wire                      done;
   wire                [7:0] rdata;

   cpu_control u_control (
      .clk    (clk),
      .nRst   (nRst),
      .status (status),
      .done   (done),
      .ctrl   (ctrl),
      .start  (start),
      .cmd    (cmd),
      .halted (halted)
   );

   cpu_datapath u_datapath (
      .clk       (clk),
      .nRst      (nRst),
      .ctrl      (ctrl),
      .mem_rdata (rdata),
      .status    (status)
   );

   cpu_bus_master u_bus_master (
      .clk       (clk),
      .nRst      (nRst),
      .start     (start),
      .cmd       (cmd),
      .done      (done),
      .rdata     (rdata),
      .mem_req   (mem_req),
      .mem_cmd   (mem_cmd),
      .mem_ack   (mem_ack),
      .mem_rdata (mem_rdata)
   );

endmodule

`default_nettype wire

//--- tests/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

   localparam int CLK_PERIOD  = 100;
   localparam int DRIVE_DELAY = 1;
   localparam int NUM_TESTS   = 12;
   localparam int HALT_LIMIT  = 150;
   localparam int IDLE_CHECK  = 20;
   localparam int WATCHDOG    = NUM_TESTS * 200;

   typedef struct packed {
      logic [47:0] prog;
      logic [2:0]  len;
      logic [7:0]  st_addr;
      logic [7:0]  st_data;
   } test_row_t;

   logic                clk;
   logic                nRst;
   logic                mem_ack;
   logic          [7:0] mem_rdata;
   wire                 mem_req;
   wire                 halted;
   wire cpu_pkg::mem_req_t mem_cmd;

   logic [7:0] mem [0:255];
   logic [7:0] wr_addr [$];
   logic [7:0] wr_data [$];
   test_row_t  tests [NUM_TESTS];
   integer     seed = 5;
   int         err_count = 0;
   int         pass_count = 0;
   int         fail_count = 0;

   cpu_top dut (
      .clk       (clk),
      .nRst      (nRst),
      .mem_req   (mem_req),
      .mem_cmd   (mem_cmd),
      .mem_ack   (mem_ack),
      .mem_rdata (mem_rdata),
      .halted    (halted)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic test_row_t make_row(input logic [47:0] prog, input logic [2:0] len,
                                          input logic [7:0] addr, input logic [7:0] data);
      test_row_t r;
      r.prog    = prog;
      r.len     = len;
      r.st_addr = addr;
      r.st_data = data;
      return r;
   endfunction

   function automatic logic [7:0] fill_byte(input logic [7:0] addr);
      return addr ^ 8'h5A;
   endfunction

   // byte = {dst, src, opcode}; regs reset to r0..r3 = 1..4
   task automatic build_table;
      tests[0]  = make_row(48'h90_B9_0F_00_00_00, 3'd3, 8'h04, 8'h05); // add r2,r1
      tests[1]  = make_row(48'h91_B9_0F_00_00_00, 3'd3, 8'h04, 8'h01); // sub r2,r1
      tests[2]  = make_row(48'h92_B9_0F_00_00_00, 3'd3, 8'h04, 8'h06); // mul r2,r1
      tests[3]  = make_row(48'h94_B9_0F_00_00_00, 3'd3, 8'h04, 8'hFD); // nand r2,r1
      tests[4]  = make_row(48'h95_B9_0F_00_00_00, 3'd3, 8'h04, 8'hFC); // nor r2,r1
      tests[5]  = make_row(48'h86_B9_0F_00_00_00, 3'd3, 8'h04, 8'h02); // xor r2,r0
      tests[6]  = make_row(48'h93_B9_0F_00_00_00, 3'd3, 8'h04, 8'h01); // div 3/2
      tests[7]  = make_row(48'h01_83_B9_0F_00_00, 3'd4, 8'h04, 8'hFF); // div by zero
      tests[8]  = make_row(48'h37_29_0F_00_00_00, 3'd3, 8'h03, 8'h04); // mov r0,r3
      // load byte 4 which holds its fill value
      tests[9]  = make_row(48'hB8_89_0F_00_00_00, 3'd3, 8'h01, 8'h5E);
      // jump over the store at byte 1
      tests[10] = make_row(48'h3A_19_79_0F_00_00, 3'd4, 8'h04, 8'h02);
      // add, mul, xor chain then a nop code before halt
      tests[11] = make_row(48'h10_22_36_19_0C_0F, 3'd6, 8'h02, 8'h0D);
   endtask

   task automatic load_program(input test_row_t row);
      int a;
      for (a = 0; a < 256; a++) begin
         mem[a] = fill_byte(a[7:0]);
      end
      for (a = 0; a < row.len; a++) begin
         mem[a] = row.prog[47 - 8 * a -: 8];
      end
   endtask

   task automatic apply_reset;
      @(posedge clk);
      #DRIVE_DELAY;
      nRst = 1'b0;
      wr_addr.delete();
      wr_data.delete();
      repeat (5) @(posedge clk);
      #DRIVE_DELAY;
      nRst = 1'b1;
   endtask

   task automatic check_idle_after_halt;
      int n;
      for (n = 0; n < IDLE_CHECK; n++) begin
         @(posedge clk);
         #DRIVE_DELAY;
         assert (halted && !mem_req) else begin
            $display("** Error at %0t: halted dropped or mem_req rose after HALT", $time);
            err_count++;
         end
      end
   endtask

   task automatic check_stores(input test_row_t row);
      assert (wr_addr.size() == 1) else begin
         $display("** Error at %0t: expected one store, saw %0d", $time, wr_addr.size());
         err_count++;
      end
      if (wr_addr.size() >= 1) begin
         assert (wr_addr[0] == row.st_addr && wr_data[0] == row.st_data) else begin
            $display("** Error at %0t: store %02h to %02h, expected %02h to %02h",
                     $time, wr_data[0], wr_addr[0], row.st_data, row.st_addr);
            err_count++;
         end
      end
   endtask

   // four-phase memory responder with random ack and release delays
   initial begin : responder
      int   wait_cnt;
      int   rel_cnt;
      logic req_prev;
      wait_cnt  = -1;
      rel_cnt   = -1;
      req_prev  = 1'b0;
      mem_ack   = 1'b0;
      mem_rdata = 8'h00;
      forever begin
         @(posedge clk);
         #DRIVE_DELAY;
         if (!nRst) begin
            mem_ack  = 1'b0;
            wait_cnt = -1;
            rel_cnt  = -1;
         end else begin
            if (mem_req && !req_prev) begin
               assert (!mem_ack) else begin
                  $display("** Error at %0t: mem_req rose while mem_ack high", $time);
                  err_count++;
               end
            end
            if (mem_ack) begin
               if (!mem_req) begin
                  // ack may linger a few cycles after req drops
                  if (rel_cnt < 0) begin
                     rel_cnt = $random(seed) & 3;
                  end
                  if (rel_cnt == 0) begin
                     mem_ack = 1'b0;
                     rel_cnt = -1;
                  end else begin
                     rel_cnt--;
                  end
               end
            end else if (mem_req) begin
               if (wait_cnt < 0) begin
                  wait_cnt = $random(seed) & 3;
               end
               if (wait_cnt == 0) begin
                  if (mem_cmd.we) begin
                     mem[mem_cmd.addr] = mem_cmd.wdata;
                     wr_addr.push_back(mem_cmd.addr);
                     wr_data.push_back(mem_cmd.wdata);
                  end else begin
                     mem_rdata = mem[mem_cmd.addr];
                  end
                  mem_ack  = 1'b1;
                  wait_cnt = -1;
               end else begin
                  wait_cnt--;
               end
            end
         end
         req_prev = mem_req;
      end
   end

   initial begin : watchdog
      #(WATCHDOG * CLK_PERIOD);
      $display("watchdog: run did not finish within %0d cycles", WATCHDOG);
      $display("=== FAIL ===");
      $finish;
   end

   initial begin : main
      int i;
      int cycles;
      int errs_before;
      nRst = 1'b0;
      build_table();
      for (i = 0; i < NUM_TESTS; i++) begin
         errs_before = err_count;
         load_program(tests[i]);
         apply_reset();
         cycles = 0;
         while (!halted && cycles < HALT_LIMIT) begin
            @(posedge clk);
            #DRIVE_DELAY;
            cycles++;
         end
         if (!halted) begin
            $display("test %0d: halted never rose within %0d cycles", i, HALT_LIMIT);
            err_count++;
         end else begin
            check_idle_after_halt();
         end
         check_stores(tests[i]);
         if (err_count == errs_before) begin
            $display("test %0d: ok", i);
            pass_count++;
         end else begin
            $display("test %0d: failed with %0d errors", i, err_count - errs_before);
            fail_count++;
         end
      end
      $display("%0d tests passed, %0d failed", pass_count, fail_count);
      if (fail_count == 0 && err_count == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- filelist.f
hw/cpu_pkg.sv
hw/cpu_alu.sv
hw/cpu_reg_block.sv
hw/cpu_datapath.sv
hw/cpu_control.sv
hw/cpu_bus_master.sv
hw/cpu_top.sv
tests/cpu_tb.sv
